// ==== hdl/pack_params.svh ====
`ifndef PACK_PARAMS_SVH
`define PACK_PARAMS_SVH

// Width of one input word.
`define PACK_WORD_W 32

// Coupler lanes behind the distributor.
`define PACK_LANES 4

// Entries per FIFO, a power of two.
`define PACK_FIFO_DEPTH 16

`endif

// ==== hdl/pack_pkg.sv ====
`include "pack_params.svh"

package pack_pkg;

  localparam int LANE_W = (`PACK_LANES > 1) ? $clog2(`PACK_LANES) : 1;

  typedef logic [`PACK_WORD_W-1:0]   word_t;
  typedef logic [2*`PACK_WORD_W-1:0] pair_t; // Earlier word in the low half.
  typedef logic [LANE_W-1:0]         lane_t;

  // Pairing machine of a coupler lane.
  typedef enum logic {
    ST_FIRST,  // Waiting for first word.
    ST_SECOND  // Waiting for second word.
  } couple_state_t;

endpackage

// ==== hdl/record_collector.sv ====
`timescale 1ns/1ps
`include "pack_params.svh"

module record_collector
  import pack_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset,
  // Lane outputs.
  input  logic [`PACK_LANES-1:0] i_pair_valid,
  input  pair_t                  i_pair_data [`PACK_LANES],
  output logic [`PACK_LANES-1:0] o_pair_ready,
  // Pair stream to outside.
  output logic                   o_valid,
  output pair_t                  o_data,
  input  logic                   i_ready
);

  localparam lane_t LAST_LANE = lane_t'(`PACK_LANES - 1);

  lane_t cur_lane;
  word_t low_half;
  word_t high_half;
  logic  xfer;
  logic  last_pair;

  // Straight from the current lane's FIFO head.
  assign o_valid = i_pair_valid[cur_lane];
  assign o_data  = i_pair_data[cur_lane];

  always_comb begin
    o_pair_ready           = '0;
    o_pair_ready[cur_lane] = i_ready;
  end

  assign low_half  = o_data[`PACK_WORD_W-1:0];
  assign high_half = o_data[2*`PACK_WORD_W-1:`PACK_WORD_W];

  assign xfer = o_valid && i_ready;

  // Either half zero means the record ends with this pair.
  assign last_pair = xfer && ((low_half == '0) || (high_half == '0));

  // Stay on a lane for the whole record, so records leave in order.
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      cur_lane <= '0;
    end else if (last_pair) begin
      if (cur_lane == LAST_LANE) begin
        cur_lane <= '0;
      end else begin
        cur_lane <= cur_lane + 1'b1;
      end
    end
  end

endmodule

// ==== hdl/record_distributor.sv ====
`timescale 1ns/1ps
`include "pack_params.svh"

module record_distributor
  import pack_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset,
  // Word stream from outside.
  input  logic                   i_valid,
  input  word_t                  i_data,
  output logic                   o_ready,
  // Lane side, data shared by all lanes.
  input  logic [`PACK_LANES-1:0] i_lane_ready,
  output logic [`PACK_LANES-1:0] o_lane_valid,
  output word_t                  o_lane_data
);

  localparam lane_t LAST_LANE = lane_t'(`PACK_LANES - 1);

  lane_t cur_lane;
  logic  xfer;
  logic  end_of_record;

  // Every lane sees the word, only one sees valid.
  assign o_lane_data = i_data;

  always_comb begin
    o_lane_valid           = '0;
    o_lane_valid[cur_lane] = i_valid;
  end

  assign o_ready = i_lane_ready[cur_lane];

  assign xfer          = i_valid && o_ready;
  assign end_of_record = xfer && (i_data == '0);

  // Next record goes to the next lane.
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      cur_lane <= '0;
    end else if (end_of_record) begin
      if (cur_lane == LAST_LANE) begin
        cur_lane <= '0;
      end else begin
        cur_lane <= cur_lane + 1'b1;
      end
    end
  end

endmodule

// ==== hdl/stream_packer.sv ====
`timescale 1ns/1ps
`include "pack_params.svh"

module stream_packer
  import pack_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_reset,
  // Word stream in.
  input  logic  i_valid,
  input  word_t i_data,
  output logic  o_ready,
  // Pair stream out.
  output logic  o_valid,
  output pair_t o_data,
  input  logic  i_ready
);

  logic [`PACK_LANES-1:0] lane_valid;
  word_t                  lane_data;
  logic [`PACK_LANES-1:0] lane_ready;

  logic [`PACK_LANES-1:0] pair_valid;
  pair_t                  pair_data [`PACK_LANES];
  logic [`PACK_LANES-1:0] pair_ready;

  record_distributor i_distributor (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_valid      (i_valid),
    .i_data       (i_data),
    .o_ready      (o_ready),
    .i_lane_ready (lane_ready),
    .o_lane_valid (lane_valid),
    .o_lane_data  (lane_data)
  );

  // One coupler per lane.
  for (genvar k = 0; k < `PACK_LANES; k++) begin : gen_lane
    word_coupler i_coupler (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_valid (lane_valid[k]),
      .i_data  (lane_data),
      .o_ready (lane_ready[k]),
      .o_valid (pair_valid[k]),
      .o_data  (pair_data[k]),
      .i_ready (pair_ready[k])
    );
  end

  record_collector i_collector (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_pair_valid (pair_valid),
    .i_pair_data  (pair_data),
    .o_pair_ready (pair_ready),
    .o_valid      (o_valid),
    .o_data       (o_data),
    .i_ready      (i_ready)
  );

endmodule

// ==== hdl/word_coupler.sv ====
`timescale 1ns/1ps
`include "pack_params.svh"

module word_coupler
  import pack_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_reset,
  // Word input.
  input  logic  i_valid,
  input  word_t i_data,
  output logic  o_ready,
  // Pair output.
  output logic  o_valid,
  output pair_t o_data,
  input  logic  i_ready
);

  couple_state_t state;
  word_t         first_word; // Held low half.

  logic  in_valid;
  word_t in_data;
  logic  in_pop;

  logic  out_push;
  pair_t out_pair;
  logic  out_ready;

  word_fifo #(
    .WIDTH  (`PACK_WORD_W)
  ) i_in_fifo (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_valid (i_valid),
    .i_data  (i_data),
    .o_ready (o_ready),
    .o_valid (in_valid),
    .o_data  (in_data),
    .i_ready (in_pop)
  );

  word_fifo #(
    .WIDTH  (2 * `PACK_WORD_W)
  ) i_out_fifo (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_valid (out_push),
    .i_data  (out_pair),
    .o_ready (out_ready),
    .o_valid (o_valid),
    .o_data  (o_data),
    .i_ready (i_ready)
  );

  // A pair is only written from the first state when the word is zero.
  assign out_pair = (state == ST_SECOND) ? {in_data, first_word} : '0;

  always_comb begin
    in_pop   = 1'b0;
    out_push = 1'b0;
    case (state)
      ST_FIRST: begin
        if (in_valid) begin
          if (in_data == '0) begin
            // Zero ends the record, pair is all zero.
            in_pop   = out_ready;
            out_push = out_ready;
          end else begin
            in_pop = 1'b1; // Goes to first_word.
          end
        end
      end
      ST_SECOND: begin
        in_pop   = in_valid && out_ready;
        out_push = in_valid && out_ready;
      end
      default: begin
        in_pop   = 1'b0;
        out_push = 1'b0;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state <= ST_FIRST;
    end else if (in_pop) begin
      if (state == ST_FIRST && in_data != '0) begin
        state <= ST_SECOND;
      end else begin
        state <= ST_FIRST;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == ST_FIRST && in_pop) begin
      first_word <= in_data;
    end
  end

endmodule

// ==== hdl/word_fifo.sv ====
`timescale 1ns/1ps
`include "pack_params.svh"

module word_fifo #(
  parameter int WIDTH = 32
) (
  input  logic             i_clk,
  input  logic             i_reset,
  // Write side.
  input  logic             i_valid,
  input  logic [WIDTH-1:0] i_data,
  output logic             o_ready,
  // Read side.
  output logic             o_valid,
  output logic [WIDTH-1:0] o_data,
  input  logic             i_ready
);

  localparam int DEPTH  = `PACK_FIFO_DEPTH;
  localparam int ADDR_W = $clog2(DEPTH);

  localparam logic [ADDR_W:0] FULL_COUNT = (ADDR_W + 1)'(DEPTH);

  logic [WIDTH-1:0]  mem [DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic [ADDR_W:0]   count;
  logic              push;
  logic              pop;

  assign o_ready = (count != FULL_COUNT);
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr]; // Head of the queue.

  assign push = i_valid && o_ready;
  assign pop  = o_valid && i_ready;

  always_ff @(posedge i_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // Pointers wrap naturally since depth is a power of two.
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Idle, or push and pop together.
      endcase
    end
  end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/pack_pkg.sv
hdl/word_fifo.sv
hdl/record_distributor.sv
hdl/word_coupler.sv
hdl/record_collector.sv
hdl/stream_packer.sv
test/stream_packer_assertions.sv
test/stream_packer_tb.sv

// ==== test/stream_packer_assertions.sv ====
`timescale 1ns/1ps

module stream_packer_assertions
  import pack_pkg::*;
(
  input logic  i_clk,
  input logic  i_reset,
  // Output side of the packer.
  input logic  i_out_valid,
  input pair_t i_out_data,
  input logic  i_out_ready
);

  int fail_count = 0;

  // A stalled pair must wait unchanged.
  property p_hold_while_stalled;
    @(posedge i_clk) disable iff (i_reset)
      (i_out_valid && !i_out_ready) |=> (i_out_valid && $stable(i_out_data));
  endproperty

  property p_idle_after_reset;
    @(posedge i_clk) i_reset |=> !i_out_valid;
  endproperty

  property p_known_on_transfer;
    @(posedge i_clk) disable iff (i_reset)
      (i_out_valid && i_out_ready) |-> !$isunknown(i_out_data);
  endproperty

  a_hold_while_stalled: assert property (p_hold_while_stalled) else begin
    $error("Output pair dropped or changed while the sink stalled");
    fail_count++;
  end

  a_idle_after_reset: assert property (p_idle_after_reset) else begin
    $error("Output valid high in the cycle after reset");
    fail_count++;
  end

  a_known_on_transfer: assert property (p_known_on_transfer) else begin
    $error("Output pair with unknown bits was transferred");
    fail_count++;
  end

endmodule

bind stream_packer stream_packer_assertions i_assertions (
  .i_clk       (i_clk),
  .i_reset     (i_reset),
  .i_out_valid (o_valid),
  .i_out_data  (o_data),
  .i_out_ready (i_ready)
);

// ==== test/stream_packer_tb.sv ====
`timescale 1ns/1ps
`include "pack_params.svh"

module stream_packer_tb
  import pack_pkg::*;
();

  typedef word_t word_list_t[$];
  typedef pair_t pair_list_t[$];

  logic  clk = 1'b0;
  logic  reset;
  logic  in_valid;
  word_t in_data;
  logic  in_ready;
  logic  out_valid;
  pair_t out_data;
  logic  out_ready;

  // Whole stimulus is built at time zero.
  word_t word_q[$];
  int    gap_q[$];
  bit    bp_q[$];
  pair_t exp_q[$];
  string exp_name_q[$];

  int seed        = 32'h64c8;
  int error_count = 0;
  int cycle_count = 0;
  int cycle_limit = 0;
  int hold_left   = 0;
  bit bp_on       = 1'b0;

  stream_packer i_stream_packer (
    .i_clk   (clk),
    .i_reset (reset),
    .i_valid (in_valid),
    .i_data  (in_data),
    .o_ready (in_ready),
    .o_valid (out_valid),
    .o_data  (out_data),
    .i_ready (out_ready)
  );

  always #50 clk = ~clk;

  // Pairs of one zero-terminated record with the earlier word low.
  function automatic pair_list_t expected_pairs(input word_list_t rec);
    pair_list_t pairs;
    int i;
    i = 0;
    while (i < rec.size()) begin
      if (rec[i] == '0) begin
        pairs.push_back('0); // Zero opens the pair and uses one word.
        i = rec.size();
      end else if (i + 1 < rec.size()) begin
        pairs.push_back({rec[i + 1], rec[i]});
        if (rec[i + 1] == '0) begin
          i = rec.size();
        end else begin
          i = i + 2;
        end
      end else begin
        i = rec.size();
      end
    end
    return pairs;
  endfunction

  task automatic add_record(input string name, input int gap_max, input bit bp,
                            input word_list_t rec);
    pair_list_t pairs;
    int gap;
    pairs = expected_pairs(rec);
    foreach (rec[i]) begin
      gap = 0;
      if (gap_max > 0) begin
        gap = int'($unsigned($random(seed)) % (gap_max + 1));
      end
      word_q.push_back(rec[i]);
      gap_q.push_back(gap);
      bp_q.push_back(bp);
    end
    foreach (pairs[i]) begin
      exp_q.push_back(pairs[i]);
      exp_name_q.push_back(name);
    end
  endtask

  task automatic add_random_record(input string name, input int max_len, input int gap_max,
                                   input bit bp);
    word_list_t rec;
    word_t w;
    int len;
    len = int'($unsigned($random(seed)) % (max_len + 1));
    repeat (len) begin
      w = $random(seed);
      if (w == '0) begin
        w = word_t'(1); // Only the terminator may be zero.
      end
      rec.push_back(w);
    end
    rec.push_back('0);
    add_record(name, gap_max, bp, rec);
  endtask

  task automatic send_word(input word_t w, input int gap);
    repeat (gap) begin
      @(negedge clk);
      in_valid = 1'b0;
    end
    @(negedge clk);
    in_valid = 1'b1;
    in_data  = w;
    @(posedge clk);
    while (!in_ready) begin
      @(posedge clk);
    end
  endtask

  // Long random sink stalls when back-pressure is on.
  always @(negedge clk) begin
    if (!bp_on) begin
      out_ready = 1'b1;
      hold_left = 0;
    end else if (hold_left > 0) begin
      hold_left--;
    end else begin
      out_ready = ~out_ready;
      if (out_ready) begin
        hold_left = int'($unsigned($random(seed)) % 6);
      end else begin
        hold_left = int'($unsigned($random(seed)) % 24);
      end
    end
  end

  always @(posedge clk) begin
    pair_t exp_pair;
    string exp_name;
    if (!reset && out_valid && out_ready) begin
      assert (exp_q.size() != 0) else begin
        $display("Output pair %h arrived when no pair was expected", out_data);
        error_count++;
      end
      if (exp_q.size() != 0) begin
        exp_pair = exp_q.pop_front();
        exp_name = exp_name_q.pop_front();
        assert (out_data === exp_pair) else begin
          $display("** Error %s: expected %h, actual %h", exp_name, exp_pair, out_data);
          error_count++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles with %0d pairs still missing", cycle_count,
               exp_q.size());
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    word_list_t rec;
    int assert_fails;
    reset     = 1'b1;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b1;

    rec = {32'h1111_1111, 32'h2222_2222, 32'h3333_3333, 32'h0};
    add_record("even", 0, 1'b0, rec);
    rec = {32'ha5a5_a5a5, 32'h0};
    add_record("even", 0, 1'b0, rec);
    rec = {32'h0101_0101, 32'h0202_0202, 32'h0303_0303, 32'h0404_0404, 32'h0505_0505, 32'h0};
    add_record("even", 0, 1'b0, rec);

    rec = {32'h4444_4444, 32'h5555_5555, 32'h0};
    add_record("odd", 0, 1'b0, rec);
    rec = {32'h0};
    add_record("odd", 0, 1'b0, rec); // Empty record.
    rec = {32'h6666_6666, 32'h7777_7777, 32'h8888_8888, 32'h9999_9999, 32'h0};
    add_record("odd", 0, 1'b0, rec);

    repeat (3 * `PACK_LANES) add_random_record("wrap", 7, 0, 1'b0);
    // Long records fill the lane FIFOs until the input stalls.
    repeat (24) add_random_record("backpressure", 31, 0, 1'b1);
    repeat (12) add_random_record("gaps", 9, 3, 1'b1);

    cycle_limit = 40 * word_q.size() + 200;

    repeat (3) @(negedge clk);
    reset = 1'b0;

    foreach (word_q[i]) begin
      bp_on = bp_q[i];
      send_word(word_q[i], gap_q[i]);
    end
    @(negedge clk);
    in_valid = 1'b0;

    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk); // Catch stray extra pairs.

    assert_fails = i_stream_packer.i_assertions.fail_count;
    $display("Errors: %0d check failures, %0d assertion failures", error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
